//--- design/nnNumericPkg.sv
package nnNumericPkg;

	// all features, weights, biases and activations are signed Q8.8

	// width of one feature, weight, bias or activation word
	localparam int dataWidth = 16;

	// binary point position inside a data word
	localparam int fracBits = 8;

	// full width of one signed product before the shift
	localparam int prodWidth = 2 * dataWidth;

	// eight shifted products plus the bias never overflow the accumulator
	localparam int accWidth = 28;

	// the rectified activation is clamped to this value on overflow
	localparam int actMax = 32767;

endpackage

//--- design/nnTopologyPkg.sv
package nnTopologyPkg;

	// shape of the fully connected layer
	localparam int numInputs = 8;
	localparam int numNeurons = 4;
	localparam int numWeights = numInputs * numNeurons;

	// configuration address map
	// weight of neuron n and input i sits at n*numInputs+i
	// bias of neuron n sits at biasBase+n
	// everything from numEntries upward is unmapped
	localparam int biasBase = numWeights;
	localparam int numEntries = numWeights + numNeurons;
	localparam int cfgAddrWidth = 6;

endpackage

//--- design/weightRegs.sv
`timescale 1ns/1ps

module weightRegs
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgAddr,
	input logic signed [nnNumericPkg::dataWidth-1:0] cfgData,
	input logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgReadAddr,
	output logic signed [nnNumericPkg::dataWidth-1:0] cfgReadData,
	output logic [nnTopologyPkg::numWeights*nnNumericPkg::dataWidth-1:0] weightBus,
	output logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0] biasBus
);

	// weights come first and biases follow in configuration address order
	logic signed [nnNumericPkg::dataWidth-1:0] entries [nnTopologyPkg::numEntries];

	logic writeHit;
	logic readHit;

	assign writeHit = cfgWrite && (int'(cfgAddr) < nnTopologyPkg::numEntries);
	assign readHit = int'(cfgReadAddr) < nnTopologyPkg::numEntries;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < nnTopologyPkg::numEntries; k++)
			begin
				entries[k] <= '0; // layer outputs stay at zero until configured
			end
		end
		else if (writeHit)
		begin
			entries[cfgAddr] <= cfgData;
		end
	end

	// readback follows the address with no register in between
	always_comb
	begin
		cfgReadData = '0; // unmapped addresses read as zero
		if (readHit)
		begin
			cfgReadData = entries[cfgReadAddr];
		end
	end

	// every entry goes to the layer in parallel
	generate
		for (genvar w = 0; w < nnTopologyPkg::numWeights; w++)
		begin : gWeight
			assign weightBus[w*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth] = entries[w];
		end

		for (genvar n = 0; n < nnTopologyPkg::numNeurons; n++)
		begin : gBias
			assign biasBus[n*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth] =
				entries[nnTopologyPkg::biasBase + n];
		end
	endgenerate

endmodule

//--- design/neuronCore.sv
`timescale 1ns/1ps

module neuronCore
(
	input logic clk,
	input logic reset,
	input logic [nnTopologyPkg::numInputs*nnNumericPkg::dataWidth-1:0] features,
	input logic [nnTopologyPkg::numInputs*nnNumericPkg::dataWidth-1:0] weights,
	input logic signed [nnNumericPkg::dataWidth-1:0] bias,
	output logic [nnNumericPkg::dataWidth-1:0] activation
);

	logic signed [nnNumericPkg::prodWidth-1:0] products [nnTopologyPkg::numInputs];
	logic signed [nnNumericPkg::accWidth-1:0] sumComb;
	logic signed [nnNumericPkg::accWidth-1:0] acc;

	// full precision products, one per feature
	generate
		for (genvar i = 0; i < nnTopologyPkg::numInputs; i++)
		begin : gProduct
			assign products[i] =
				$signed(features[i*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth]) *
				$signed(weights[i*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth]);
		end
	endgenerate

	// each product is floored back to Q8.8 before it is added
	always_comb
	begin
		sumComb = nnNumericPkg::accWidth'(bias); // sign extended bias
		for (int i = 0; i < nnTopologyPkg::numInputs; i++)
		begin
			sumComb = sumComb +
				nnNumericPkg::accWidth'(products[i] >>> nnNumericPkg::fracBits);
		end
	end

	// stage one holds the dot product plus bias
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
		end
		else
		begin
			acc <= sumComb;
		end
	end

	// stage two is the rectifier with an upper clamp
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (acc[nnNumericPkg::accWidth-1])
		begin
			activation <= '0; // negative sums are cut off
		end
		else if (acc > nnNumericPkg::accWidth'(nnNumericPkg::actMax))
		begin
			activation <= nnNumericPkg::dataWidth'(nnNumericPkg::actMax);
		end
		else
		begin
			activation <= acc[nnNumericPkg::dataWidth-1:0];
		end
	end

endmodule

//--- design/denseLayer.sv
`timescale 1ns/1ps

module denseLayer
(
	input logic clk,
	input logic reset,
	input logic [nnTopologyPkg::numInputs*nnNumericPkg::dataWidth-1:0] featureIn,
	input logic [nnTopologyPkg::numWeights*nnNumericPkg::dataWidth-1:0] weightBus,
	input logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0] biasBus,
	output logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0] activationOut
);

	// one registered copy of the features is shared by every neuron
	logic [nnTopologyPkg::numInputs*nnNumericPkg::dataWidth-1:0] featureReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featureReg <= '0;
		end
		else
		begin
			featureReg <= featureIn; // a new vector may arrive every cycle
		end
	end

	// neuron n takes weights n*numInputs up to n*numInputs+numInputs-1
	generate
		for (genvar n = 0; n < nnTopologyPkg::numNeurons; n++)
		begin : gNeuron
			neuronCore core
			(
				.clk(clk),
				.reset(reset),
				.features(featureReg),
				.weights(weightBus[n*nnTopologyPkg::numInputs*nnNumericPkg::dataWidth +:
					nnTopologyPkg::numInputs*nnNumericPkg::dataWidth]),
				.bias(biasBus[n*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth]),
				.activation(activationOut[n*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth])
			);
		end
	endgenerate

endmodule

//--- design/nnLayerTop.sv
`timescale 1ns/1ps

module nnLayerTop
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgAddr,
	input logic signed [nnNumericPkg::dataWidth-1:0] cfgData,
	input logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgReadAddr,
	output logic signed [nnNumericPkg::dataWidth-1:0] cfgReadData,
	input logic [nnTopologyPkg::numInputs*nnNumericPkg::dataWidth-1:0] featureIn,
	output logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0] activationOut
);

	// parameters from the configuration bank to the datapath
	logic [nnTopologyPkg::numWeights*nnNumericPkg::dataWidth-1:0] weightBus;
	logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0] biasBus;

	weightRegs regs
	(
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.cfgReadAddr(cfgReadAddr),
		.cfgReadData(cfgReadData),
		.weightBus(weightBus),
		.biasBus(biasBus)
	);

	// three edges from featureIn to activationOut
	denseLayer layer
	(
		.clk(clk),
		.reset(reset),
		.featureIn(featureIn),
		.weightBus(weightBus),
		.biasBus(biasBus),
		.activationOut(activationOut)
	);

endmodule

//--- tests/nnLayerTop_props.sv
`timescale 1ns/1ps

module nnLayerTopProps
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgAddr,
	input logic signed [nnNumericPkg::dataWidth-1:0] cfgData,
	input logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgReadAddr,
	input logic signed [nnNumericPkg::dataWidth-1:0] cfgReadData,
	input logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0] activationOut
);

	activationClearAfterReset: assert property (@(posedge clk)
		$past(reset) |-> activationOut == '0)
		else $error("activationOut is not zero one cycle after reset");

	// the rectifier never lets a negative activation through
	generate
		for (genvar n = 0; n < nnTopologyPkg::numNeurons; n++)
		begin : gSign
			signBitClear: assert property (@(posedge clk) disable iff (reset)
				!activationOut[n*nnNumericPkg::dataWidth + nnNumericPkg::dataWidth - 1])
				else $error("activation %0d has its sign bit set", n);
		end
	endgenerate

	readbackAfterWrite: assert property (@(posedge clk) disable iff (reset)
		($past(cfgWrite) && !$past(reset) &&
		int'($past(cfgAddr)) < nnTopologyPkg::numEntries && cfgReadAddr == $past(cfgAddr))
		|-> cfgReadData == $past(cfgData))
		else $error("cfgReadData does not show the value written one cycle earlier");

	unmappedReadsZero: assert property (@(posedge clk)
		int'(cfgReadAddr) >= nnTopologyPkg::numEntries |-> cfgReadData == '0)
		else $error("cfgReadData is not zero for an unmapped address");

endmodule

bind nnLayerTop nnLayerTopProps props (.*);

//--- tests/nnLayerTb.sv
`timescale 1ns/1ps

module nnLayerTb;

	typedef logic [nnNumericPkg::dataWidth-1:0] wordT;
	typedef logic [nnTopologyPkg::numInputs*nnNumericPkg::dataWidth-1:0] featureVecT;
	typedef logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0] activationVecT;
	typedef enum logic {stepWrite, stepVector} stepKindT;

	typedef struct packed {
		stepKindT kind;
		logic [nnTopologyPkg::cfgAddrWidth-1:0] addr;
		wordT data;
		wordT readExpect;
		featureVecT features;
	} stepT;

	logic clk;
	logic reset;
	logic cfgWrite;
	logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgAddr;
	logic signed [nnNumericPkg::dataWidth-1:0] cfgData;
	logic [nnTopologyPkg::cfgAddrWidth-1:0] cfgReadAddr;
	logic signed [nnNumericPkg::dataWidth-1:0] cfgReadData;
	featureVecT featureIn;
	activationVecT activationOut;

	stepT steps [$];
	// top bit marks a checked slot
	logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth:0] pipeline [$];
	int modelEntries [nnTopologyPkg::numEntries];
	logic readPending;
	wordT readExpected;
	int cycleCount;
	int timeoutLimit;

	nnLayerTop uut
	(
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.cfgReadAddr(cfgReadAddr),
		.cfgReadData(cfgReadData),
		.featureIn(featureIn),
		.activationOut(activationOut)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > timeoutLimit)
		begin
			stopWithFailure($sformatf("timeout, the run did not finish within %0d cycles",
				timeoutLimit));
		end
	end

	task automatic stopWithFailure(string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(string name, wordT actual, wordT expected);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("MISMATCH %s: actual 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	// starting weights give neuron 0 positive, neuron 1 negative and neurons 2 and 3 mixed signs
	function automatic int initialWeight(int n, int i);
		case (n)
			0: return 64 + 16 * i;
			1: return -(32 + 8 * i);
			2: return (i % 2 == 0) ? 128 : -96;
			default: return 256 - 48 * i;
		endcase
	endfunction

	function automatic int initialBias(int n);
		case (n)
			0: return 256;
			1: return 128;
			2: return -64; // a zero vector still gives zero here
			default: return 32;
		endcase
	endfunction

	function automatic featureVecT repeatFeature(wordT value);
		return {nnTopologyPkg::numInputs{value}};
	endfunction

	function automatic featureVecT randomFeatures();
		featureVecT v;
		for (int i = 0; i < nnTopologyPkg::numInputs; i++)
		begin
			v[i*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth] = wordT'($urandom);
		end
		return v;
	endfunction

	task automatic addWrite(int addr, wordT value, wordT readExpect);
		stepT s;
		s.kind = stepWrite;
		s.addr = nnTopologyPkg::cfgAddrWidth'(addr);
		s.data = value;
		s.readExpect = readExpect;
		s.features = '0;
		steps.push_back(s);
	endtask

	task automatic addVector(featureVecT features);
		stepT s;
		s.kind = stepVector;
		s.addr = '0;
		s.data = '0;
		s.readExpect = '0;
		s.features = features;
		steps.push_back(s);
	endtask

	task automatic buildSteps();
		for (int n = 0; n < nnTopologyPkg::numNeurons; n++)
		begin
			for (int i = 0; i < nnTopologyPkg::numInputs; i++)
			begin
				addWrite(n * nnTopologyPkg::numInputs + i, wordT'(initialWeight(n, i)),
					wordT'(initialWeight(n, i)));
			end
		end
		for (int n = 0; n < nnTopologyPkg::numNeurons; n++)
		begin
			addWrite(nnTopologyPkg::biasBase + n, wordT'(initialBias(n)),
				wordT'(initialBias(n)));
		end
		addWrite(40, 16'h1234, 16'h0000); // address 40 lies outside the map and must not stick
		addVector(repeatFeature(16'h0200));
		addVector({16'h0100, 16'hff80, 16'h0040, 16'h0000,
			16'h0300, 16'hffc0, 16'h0020, 16'h0010});
		addVector(repeatFeature(16'hfe00)); // negative sums on neurons 0, 2 and 3
		addVector(repeatFeature(16'h0000));
		addVector(repeatFeature(16'h7fff)); // neuron 0 clamps
		addVector(repeatFeature(16'h8000)); // neuron 1 clamps
		addWrite(3 * nnTopologyPkg::numInputs, 16'h7fff, 16'h7fff);
		addVector(repeatFeature(16'h7fff));
		repeat (12) addVector(randomFeatures());
		addWrite(5, 16'hfc00, 16'hfc00); // the held vector is sampled again with the new weight
		repeat (12) addVector(randomFeatures());
		addWrite(nnTopologyPkg::biasBase + 1, 16'h0400, 16'h0400);
		repeat (8) addVector(randomFeatures());
	endtask

	// Q8.8 products are floored, summed wide, then rectified and clamped
	function automatic activationVecT modelLayer(featureVecT features);
		activationVecT result;
		longint sum;
		longint feature;
		longint weight;
		result = '0;
		for (int n = 0; n < nnTopologyPkg::numNeurons; n++)
		begin
			sum = longint'(modelEntries[nnTopologyPkg::biasBase + n]);
			for (int i = 0; i < nnTopologyPkg::numInputs; i++)
			begin
				feature = longint'($signed(
					features[i*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth]));
				weight = longint'(modelEntries[n * nnTopologyPkg::numInputs + i]);
				sum = sum + ((feature * weight) >>> nnNumericPkg::fracBits);
			end
			if (sum < 0)
			begin
				sum = 0;
			end
			else if (sum > nnNumericPkg::actMax)
			begin
				sum = nnNumericPkg::actMax;
			end
			result[n*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth] = wordT'(sum);
		end
		return result;
	endfunction

	task automatic checkActivations(activationVecT expected);
		for (int n = 0; n < nnTopologyPkg::numNeurons; n++)
		begin
			checkValue($sformatf("activationOut[%0d]", n),
				activationOut[n*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth],
				expected[n*nnNumericPkg::dataWidth +: nnNumericPkg::dataWidth]);
		end
	endtask

	task automatic checkResetReadback();
		for (int a = 0; a < (1 << nnTopologyPkg::cfgAddrWidth); a++)
		begin
			cfgReadAddr = nnTopologyPkg::cfgAddrWidth'(a);
			#1;
			checkValue($sformatf("cfgReadData at address %0d", a), cfgReadData, '0);
		end
		cfgReadAddr = '0;
	endtask

	task automatic checkDueResults();
		logic [nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth:0] entry;
		if (readPending)
		begin
			checkValue($sformatf("cfgReadData at address %0d", cfgReadAddr), cfgReadData,
				readExpected);
			readPending = 1'b0;
		end
		if (pipeline.size() == 3) // results leave three edges after the vector was driven
		begin
			entry = pipeline.pop_front();
			if (entry[nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth])
			begin
				checkActivations(entry[nnTopologyPkg::numNeurons*nnNumericPkg::dataWidth-1:0]);
			end
		end
	endtask

	task automatic applyStep(stepT s);
		cfgWrite = 1'b0;
		if (s.kind == stepWrite)
		begin
			cfgWrite = 1'b1;
			cfgAddr = s.addr;
			cfgData = s.data;
			cfgReadAddr = s.addr;
			readPending = 1'b1;
			readExpected = s.readExpect;
			if (int'(s.addr) < nnTopologyPkg::numEntries)
			begin
				modelEntries[s.addr] = int'($signed(s.data));
			end
		end
		else
		begin
			featureIn = s.features;
		end
		pipeline.push_back({1'b1, modelLayer(featureIn)});
	endtask

	initial
	begin
		void'($urandom(14));
		clk = 1'b0;
		reset = 1'b1;
		cfgWrite = 1'b0;
		cfgAddr = '0;
		cfgData = '0;
		cfgReadAddr = '0;
		featureIn = '0;
		readPending = 1'b0;
		readExpected = '0;
		cycleCount = 0;
		foreach (modelEntries[k])
		begin
			modelEntries[k] = 0;
		end
		buildSteps();
		timeoutLimit = steps.size() + 20;
		repeat (4) @(posedge clk);
		#5;
		reset = 1'b0;
		checkActivations('0);
		checkResetReadback();
		foreach (steps[k])
		begin
			@(posedge clk);
			#5;
			checkDueResults();
			applyStep(steps[k]);
		end
		repeat (3)
		begin
			@(posedge clk);
			#5;
			checkDueResults();
			pipeline.push_back('0);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- vlog.f
design/nnNumericPkg.sv
design/nnTopologyPkg.sv
design/weightRegs.sv
design/neuronCore.sv
design/denseLayer.sv
design/nnLayerTop.sv
tests/nnLayerTop_props.sv
tests/nnLayerTb.sv

//--- Makefile
# Verilator build and run of the layer testbench

VERILATOR ?= verilator
TOP = nnLayerTb
FILELIST = vlog.f
BUILD_DIR = obj_dir
VFLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

SOURCES = $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the simulator exits with a failing status when the testbench stops on an error
test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
